/* filelist.f */
lsu_types_pkg.sv
lsu_ops_pkg.sv
load_unit.sv
store_unit.sv
store_buffer.sv
memory_controller.sv
load_store_unit.sv
load_store_unit_assertions.sv
tb_load_store_unit.sv

/* load_store_unit.sv */
// Load/store unit top level joining load unit, store unit, store buffer and memory controller
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import lsu_types_pkg::*, lsu_ops_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        load_valid_i,
    input  data_word_t  load_address_i,
    input  ldu_opcode_t load_opcode_i,
    input  logic        load_signed_i,
    input  logic        store_valid_i,
    input  data_word_t  store_address_i,
    input  data_word_t  store_data_i,
    output data_word_t  load_data_o,
    output logic        load_data_valid_o,
    output logic        load_idle_o,
    output logic        store_idle_o,
    output logic        mem_req_o,
    output logic        mem_we_o,
    output data_word_t  mem_addr_o,
    output data_word_t  mem_wdata_o,
    input  data_word_t  mem_rdata_i,
    input  logic        mem_ready_i
);

    ldu_uop_t   load_uop;
    logic       stu_match, sb_match, sb_push, sb_full;
    data_word_t stu_data, sb_data, sb_push_address, sb_push_data;
    logic       ld_request, ld_valid, st_request, st_done;
    data_word_t ld_address, ld_data, st_address, st_data;

    assign load_uop = '{opcode: load_opcode_i, signed_load: load_signed_i};

    load_unit load_unit_i (
        .clk_i, .rst_n_i,
        .valid_operation_i (load_valid_i), .load_address_i, .operation_i (load_uop),
        .stu_match_i (stu_match), .stu_data_i (stu_data),
        .sb_match_i (sb_match), .sb_data_i (sb_data),
        .ld_request_o (ld_request), .ld_address_o (ld_address),
        .ld_valid_i (ld_valid), .ld_data_i (ld_data),
        .data_loaded_o (load_data_o), .data_valid_o (load_data_valid_o), .idle_o (load_idle_o)
    );

    store_unit store_unit_i (
        .clk_i, .rst_n_i,
        .valid_store_i (store_valid_i), .store_address_i, .store_data_i, .load_address_i,
        .sb_full_i (sb_full), .match_o (stu_match), .fwd_data_o (stu_data),
        .sb_push_o (sb_push), .sb_address_o (sb_push_address), .sb_data_o (sb_push_data),
        .idle_o (store_idle_o)
    );

    store_buffer store_buffer_i (
        .clk_i, .rst_n_i,
        .push_i (sb_push), .push_address_i (sb_push_address), .push_data_i (sb_push_data),
        .full_o (sb_full), .load_address_i, .match_o (sb_match), .fwd_data_o (sb_data),
        .st_request_o (st_request), .st_address_o (st_address), .st_data_o (st_data),
        .st_done_i (st_done)
    );

    memory_controller memory_controller_i (
        .clk_i, .rst_n_i,
        .ld_request_i (ld_request), .ld_address_i (ld_address),
        .ld_valid_o (ld_valid), .ld_data_o (ld_data),
        .st_request_i (st_request), .st_address_i (st_address), .st_data_i (st_data),
        .st_done_o (st_done),
        .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_rdata_i, .mem_ready_i
    );

endmodule : load_store_unit

`default_nettype wire

/* load_store_unit_assertions.sv */
// Concurrent assertions on the memory port, store buffer occupancy and load result pulses
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_assertions import lsu_types_pkg::*; (
    input logic clk_i,
    input logic rst_n_i,
    input logic mem_req_i,
    input logic mem_ready_i,
    input logic push_i,
    input logic pop_i,
    input logic full_i,
    input logic load_valid_i,
    input logic data_valid_i
);

    logic                  outstanding_q;
    logic [SB_PTR_WIDTH:0] occupancy_q;

    // A transaction stays open from its request until the ready pulse
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_i) begin
            outstanding_q <= 1'b1;
        end else if (mem_ready_i) begin
            outstanding_q <= 1'b0;
        end
    end

    // Entries in the buffer, counted from the push and write completion pulses
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            occupancy_q <= '0;
        end else begin
            occupancy_q <= occupancy_q + (SB_PTR_WIDTH+1)'(push_i)
                                       - (SB_PTR_WIDTH+1)'(pop_i);
        end
    end

    no_overlapping_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i |-> !outstanding_q)
        else $error("memory request issued during an outstanding transaction");

    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> (occupancy_q < SB_DEPTH))
        else $error("store buffer push while all entries are taken");

    full_flag_matches_occupancy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        full_i == (occupancy_q == SB_DEPTH))
        else $error("store buffer full flag disagrees with its occupancy");

    // A second pulse in a row is only legal for a load taken in the completing cycle
    single_cycle_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (data_valid_i && !load_valid_i) |=> !data_valid_i)
        else $error("load data valid held longer than one cycle");

endmodule : load_store_unit_assertions

bind load_store_unit load_store_unit_assertions load_store_unit_assertions_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mem_req_i    (mem_req_o),
    .mem_ready_i  (mem_ready_i),
    .push_i       (sb_push),
    .pop_i        (st_done),
    .full_i       (sb_full),
    .load_valid_i (load_valid_i),
    .data_valid_i (load_data_valid_o)
);

`default_nettype wire

/* load_unit.sv */
// Load unit with IDLE/WAIT FSM, forwarding capture, memory request and subword slicing
`timescale 1ns/1ps
`default_nettype none

module load_unit import lsu_types_pkg::*, lsu_ops_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       valid_operation_i,
    input  data_word_t load_address_i,
    input  ldu_uop_t   operation_i,
    input  logic       stu_match_i,
    input  data_word_t stu_data_i,
    input  logic       sb_match_i,
    input  data_word_t sb_data_i,
    output logic       ld_request_o,
    output data_word_t ld_address_o,
    input  logic       ld_valid_i,
    input  data_word_t ld_data_i,
    output data_word_t data_loaded_o,
    output logic       data_valid_o,
    output logic       idle_o
);

    load_fsm_state_t state_q, state_d;
    logic            fwd_q, fwd_d;
    logic            done;
    logic            idle;
    logic            accept;
    ldu_uop_t        uop_q;
    data_word_t      address_q;
    data_word_t      fwd_data_q;
    data_word_t      data_selected;
    data_word_t      data_sliced;
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;

    // ------------------------------
    // Control
    // ------------------------------

    // A pending load finishes when forwarded data is held or memory answers
    assign done   = (state_q == WAIT) & (fwd_q | ld_valid_i);
    // The unit takes a new load in the same cycle that the old one completes
    assign idle   = (state_q == IDLE) | done;
    assign accept = valid_operation_i & idle;

    assign idle_o       = idle;
    assign data_valid_o = done;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            fwd_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            fwd_q   <= fwd_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        fwd_d        = fwd_q;
        ld_request_o = 1'b0;
        if (done) begin
            state_d = IDLE;
            fwd_d   = 1'b0;
        end
        // Either store source makes the memory read unnecessary
        if (accept) begin
            state_d      = WAIT;
            fwd_d        = stu_match_i | sb_match_i;
            ld_request_o = ~(stu_match_i | sb_match_i);
        end
    end

    // The controller latches the address together with the request pulse
    assign ld_address_o = load_address_i;

    // ------------------------------
    // Datapath
    // ------------------------------

    // The store unit holds a younger store than any buffer entry
    always_ff @(posedge clk_i) begin
        if (accept) begin
            uop_q      <= operation_i;
            address_q  <= load_address_i;
            fwd_data_q <= stu_match_i ? stu_data_i : sb_data_i;
        end
    end

    always_comb begin
        data_selected = fwd_q ? fwd_data_q : ld_data_i;
        byte_sel      = data_selected.word8[address_q[1:0]];
        half_sel      = data_selected.word16[address_q[1]];
        // Fill bits copy the sign only for a signed load
        case (uop_q.opcode)
            LDB:     data_sliced.word32 = {{(DATA_WIDTH-8){uop_q.signed_load & byte_sel[7]}},
                                           byte_sel};
            LDH:     data_sliced.word32 = {{(DATA_WIDTH-16){uop_q.signed_load & half_sel[15]}},
                                           half_sel};
            default: data_sliced = data_selected;
        endcase
    end

    assign data_loaded_o = data_sliced;

endmodule : load_unit

`default_nettype wire

/* lsu_ops_pkg.sv */
// Load opcodes, load micro-op fields and FSM state enums
`default_nettype none

package lsu_ops_pkg;

    // Access size of a load
    typedef enum logic [1:0] {LDB, LDH, LDW} ldu_opcode_t;

    // Micro-op handed to the load unit by the execute stage
    typedef struct packed {
        ldu_opcode_t opcode;
        logic        signed_load;
    } ldu_uop_t;

    // Load unit waits in WAIT for forwarded or memory data
    typedef enum logic {IDLE, WAIT} load_fsm_state_t;

    // The memory port is either free or running one read or one write
    typedef enum logic [1:0] {FREE, READ, WRITE} mem_ctrl_state_t;

endpackage : lsu_ops_pkg

`default_nettype wire

/* lsu_types_pkg.sv */
// Data word width, word/byte/half word view type and store buffer sizing
`default_nettype none

package lsu_types_pkg;

    // Width of every address and data word handled by the unit
    localparam int DATA_WIDTH = 32;

    // The same 32 bits seen as a word, as four bytes or as two half words
    // Byte 0 and half word 0 sit in the least significant bits
    typedef union packed {
        logic [DATA_WIDTH-1:0]               word32;
        logic [DATA_WIDTH/8-1:0][7:0]        word8;
        logic [DATA_WIDTH/16-1:0][15:0]      word16;
    } data_word_t;

    // ------------------------------
    // Store buffer sizing
    // ------------------------------

    // Number of entries held between the store unit and memory
    localparam int SB_DEPTH = 4;

    // Head and tail pointers wrap naturally at this width
    localparam int SB_PTR_WIDTH = 2;

endpackage : lsu_types_pkg

`default_nettype wire

/* memory_controller.sv */
// Single-port memory controller arbitrating load reads and store buffer drains
`timescale 1ns/1ps
`default_nettype none

module memory_controller import lsu_types_pkg::*, lsu_ops_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       ld_request_i,
    input  data_word_t ld_address_i,
    output logic       ld_valid_o,
    output data_word_t ld_data_o,
    input  logic       st_request_i,
    input  data_word_t st_address_i,
    input  data_word_t st_data_i,
    output logic       st_done_o,
    output logic       mem_req_o,
    output logic       mem_we_o,
    output data_word_t mem_addr_o,
    output data_word_t mem_wdata_o,
    input  data_word_t mem_rdata_i,
    input  logic       mem_ready_i
);

    mem_ctrl_state_t state_q;
    logic            ld_pending_q;
    data_word_t      ld_address_q;

    // Only one transaction is in flight so a ready pulse belongs to the current state
    assign ld_valid_o = (state_q == READ) & mem_ready_i;
    assign st_done_o  = (state_q == WRITE) & mem_ready_i;
    assign ld_data_o  = mem_rdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= FREE;
            ld_pending_q <= 1'b0;
            mem_req_o    <= 1'b0;
            mem_we_o     <= 1'b0;
        end else begin
            mem_req_o <= 1'b0;
            case (state_q)
                // A waiting load goes out before any buffer drain
                FREE: begin
                    if (ld_pending_q) begin
                        state_q      <= READ;
                        ld_pending_q <= 1'b0;
                        mem_req_o    <= 1'b1;
                        mem_we_o     <= 1'b0;
                    end else if (st_request_i) begin
                        state_q   <= WRITE;
                        mem_req_o <= 1'b1;
                        mem_we_o  <= 1'b1;
                    end
                end
                default: begin
                    if (mem_ready_i) begin
                        state_q <= FREE;
                    end
                end
            endcase
            // The request is remembered even while a write is still running
            if (ld_request_i) begin
                ld_pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ld_request_i) begin
            ld_address_q <= ld_address_i;
        end
        if (state_q == FREE) begin
            mem_addr_o  <= ld_pending_q ? ld_address_q : st_address_i;
            mem_wdata_o <= st_data_i;
        end
    end

endmodule : memory_controller

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and report failure when the log holds the fail line
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_load_store_unit -o sim_lsu &&
./obj_dir/sim_lsu > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* store_buffer.sv */
// Four-entry store FIFO with youngest-match forwarding and drain to memory
`timescale 1ns/1ps
`default_nettype none

module store_buffer import lsu_types_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       push_i,
    input  data_word_t push_address_i,
    input  data_word_t push_data_i,
    output logic       full_o,
    input  data_word_t load_address_i,
    output logic       match_o,
    output data_word_t fwd_data_o,
    output logic       st_request_o,
    output data_word_t st_address_o,
    output data_word_t st_data_o,
    input  logic       st_done_i
);

    data_word_t              address_q [SB_DEPTH];
    data_word_t              data_q    [SB_DEPTH];
    logic [SB_PTR_WIDTH-1:0] head_q, tail_q;
    logic [SB_PTR_WIDTH:0]   count_q;
    logic                    do_push, do_pop;
    logic [SB_PTR_WIDTH-1:0] idx;

    assign full_o       = (count_q == (SB_PTR_WIDTH+1)'(SB_DEPTH));
    assign st_request_o = (count_q != '0);
    assign do_push      = push_i & ~full_o;
    // The head leaves only once memory has acknowledged its write
    assign do_pop       = st_done_i & st_request_o;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            address_q[tail_q] <= push_address_i;
            data_q[tail_q]    <= push_data_i;
        end
    end

    // ------------------------------
    // Forwarding search
    // ------------------------------

    // Walk from oldest to youngest so that a later hit overrides an earlier one
    always_comb begin
        match_o    = 1'b0;
        fwd_data_o = '0;
        idx        = head_q;
        for (int i = 0; i < SB_DEPTH; i++) begin
            idx = head_q + SB_PTR_WIDTH'(i);
            if ((int'(count_q) > i) &&
                (address_q[idx][DATA_WIDTH-1:2] == load_address_i[DATA_WIDTH-1:2])) begin
                match_o    = 1'b1;
                fwd_data_o = data_q[idx];
            end
        end
    end

    // The head entry stays put until its write completes
    assign st_address_o = address_q[head_q];
    assign st_data_o    = data_q[head_q];

endmodule : store_buffer

`default_nettype wire

/* store_unit.sv */
// Store unit holding one accepted store until the store buffer takes it
`timescale 1ns/1ps
`default_nettype none

module store_unit import lsu_types_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       valid_store_i,
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,
    input  data_word_t load_address_i,
    input  logic       sb_full_i,
    output logic       match_o,
    output data_word_t fwd_data_o,
    output logic       sb_push_o,
    output data_word_t sb_address_o,
    output data_word_t sb_data_o,
    output logic       idle_o
);

    logic       valid_q;
    logic       accept;
    logic       push;
    data_word_t address_q;
    data_word_t data_q;

    // A new store is only taken while nothing is held
    assign accept = valid_store_i & ~valid_q;
    // The held store moves to the buffer as soon as a slot is free
    assign push   = valid_q & ~sb_full_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (push) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            address_q <= store_address_i;
            data_q    <= store_data_i;
        end
    end

    // Stores write whole words so only the word address is compared
    assign match_o    = valid_q & (address_q[DATA_WIDTH-1:2] == load_address_i[DATA_WIDTH-1:2]);
    assign fwd_data_o = data_q;

    assign sb_push_o    = push;
    assign sb_address_o = address_q;
    assign sb_data_o    = data_q;
    assign idle_o       = ~valid_q;

endmodule : store_unit

`default_nettype wire

/* tb_load_store_unit.sv */
// Testbench for the load/store unit with xorshift stimulus, memory model, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_load_store_unit import lsu_types_pkg::*, lsu_ops_pkg::*; ();

    localparam logic [31:0] SEED           = 32'hdf8b;
    localparam int          N_OPS          = 400;
    localparam int          N_BURST        = 24;
    localparam int          ACCEPT_TIMEOUT = 200;
    localparam int          DRAIN_TIMEOUT  = 2000;
    localparam int          MEM_WORDS      = 16;
    // Low six bits stay clear so the 16-word window indexes directly
    localparam logic [31:0] BASE_ADDR      = 32'h0000_3c00;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        load_valid_i, load_signed_i, store_valid_i;
    ldu_opcode_t load_opcode_i;
    data_word_t  load_address_i, store_address_i, store_data_i, load_data_o;
    data_word_t  mem_addr_o, mem_wdata_o, mem_rdata_i;
    logic        load_data_valid_o, load_idle_o, store_idle_o;
    logic        mem_req_o, mem_we_o, mem_ready_i;

    // Reference array follows accepted stores, memory model follows completed writes
    logic [31:0] ref_mem   [MEM_WORDS];
    logic [31:0] mem_model [MEM_WORDS];
    logic [31:0] expect_q [$];
    logic [31:0] read_q [$];
    logic [63:0] store_q [$];
    logic [31:0] stim_rng, lat_rng, txn_addr, txn_data;
    logic [3:0]  last_store_word = 4'd0;
    logic        txn_open, txn_we, fire, slow_mem, store_idle_prev;
    int          txn_wait, stall_cycles;

    load_store_unit load_store_unit_i (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Power-up contents differ for every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    // Byte or half word picked by the low address bits, then sign or zero filled
    function automatic logic [31:0] expected_slice(input logic [31:0] w, input logic [1:0] off,
                                                   input ldu_opcode_t opc, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = off[1] ? w[31:16] : w[15:0];
        case (opc)
            LDB:     return sgn ? {{24{b[7]}}, b} : {24'd0, b};
            LDH:     return sgn ? {{16{h[15]}}, h} : {16'd0, h};
            default: return w;
        endcase
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] %0t ns: %s: got %h, expected %h",
                                        $time, what, actual, expected));
        end
    endtask

    // Returns at the falling edge before the accepting rising edge
    task automatic wait_accept(input logic is_load);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            if (cycles > ACCEPT_TIMEOUT) begin
                stop_with_failure(is_load ? "A load was never accepted by the load unit"
                                          : "A store was never accepted by the store unit");
            end
        end while (!(is_load ? load_idle_o : store_idle_o));
    endtask

    // Kind 0 leaves the cycle idle, 1 issues a load and 2 a store
    task automatic issue_operation(input int kind);
        logic [31:0] r;
        logic [3:0]  widx;
        logic [1:0]  off;
        ldu_opcode_t opc;
        @(posedge clk_i);
        stim_rng = xorshift(stim_rng);
        r        = stim_rng;
        load_valid_i  <= (kind == 1);
        store_valid_i <= (kind == 2);
        if (kind == 1) begin
            // Half the loads hit the last stored word so forwarding is exercised
            widx = r[6] ? last_store_word : r[5:2];
            opc  = (r[1:0] == 2'd0) ? LDB : ((r[1:0] == 2'd1) ? LDH : LDW);
            off  = (opc == LDB) ? r[9:8] : ((opc == LDH) ? {r[9], 1'b0} : 2'd0);
            load_opcode_i  <= opc;
            load_signed_i  <= r[10];
            load_address_i <= BASE_ADDR | {26'd0, widx, off};
        end else if (kind == 2) begin
            widx            = r[5:2];
            last_store_word = widx;
            stim_rng        = xorshift(stim_rng);
            store_address_i <= BASE_ADDR | {26'd0, widx, 2'd0};
            store_data_i    <= stim_rng;
        end
        if (kind != 0) begin
            wait_accept(kind == 1);
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------

    always @(posedge clk_i) begin
        mem_ready_i <= fire;
        if (fire && txn_we) begin
            mem_model[txn_addr[5:2]] <= txn_data;
        end else if (fire) begin
            mem_rdata_i <= mem_model[txn_addr[5:2]];
        end
    end

    // ------------------------------
    // Monitor and reference model
    // ------------------------------

    // Everything is sampled mid-cycle, where DUT outputs and driven inputs are settled
    always @(negedge clk_i) begin
        logic forwarded;
        if (rst_n_i) begin
            if (load_data_valid_o) begin
                if (expect_q.size() == 0) begin
                    stop_with_failure("Load data came back with no load outstanding");
                end else begin
                    check_value(load_data_o, expect_q.pop_front(), "load data");
                end
            end
            // A load sees every store accepted before it
            if (load_valid_i && load_idle_o) begin
                expect_q.push_back(expected_slice(ref_mem[load_address_i.word32[5:2]],
                                   load_address_i.word32[1:0], load_opcode_i, load_signed_i));
                forwarded = 1'b0;
                foreach (store_q[i]) begin
                    if (store_q[i][63:34] == load_address_i.word32[31:2]) begin
                        forwarded = 1'b1;
                    end
                end
                if (!forwarded) begin
                    read_q.push_back(load_address_i.word32 & ~32'h3);
                end
            end
            if (store_valid_i && store_idle_o) begin
                ref_mem[store_address_i.word32[5:2]] = store_data_i;
                store_q.push_back({store_address_i.word32, store_data_i.word32});
            end
            // Two low samples in a row mean the store unit is held back by a full buffer
            if (!store_idle_o && !store_idle_prev) begin
                stall_cycles++;
            end
            store_idle_prev = store_idle_o;
            // Drains must leave in program order
            if (mem_ready_i && txn_we) begin
                if (store_q.size() == 0) begin
                    stop_with_failure("A memory write completed with no store outstanding");
                end else begin
                    check_value(txn_addr, store_q[0][63:32], "drain address");
                    check_value(txn_data, store_q[0][31:0], "drain data");
                    void'(store_q.pop_front());
                end
            end
            if (mem_ready_i) begin
                txn_open = 1'b0;
            end
            if (mem_req_o) begin
                if (txn_open) begin
                    stop_with_failure("A memory request came while another was outstanding");
                end
                txn_open = 1'b1;
                txn_we   = mem_we_o;
                txn_addr = mem_addr_o;
                txn_data = mem_wdata_o;
                lat_rng  = xorshift(lat_rng);
                txn_wait = slow_mem ? 4 : 1 + int'(lat_rng[1:0]);
                if (!mem_we_o && read_q.size() == 0) begin
                    stop_with_failure("Memory saw a read that no load needed");
                end else if (!mem_we_o) begin
                    check_value(mem_addr_o.word32 & ~32'h3, read_q.pop_front(), "read address");
                end
            end
            fire = 1'b0;
            if (txn_open && txn_wait != 0) begin
                txn_wait--;
                fire = (txn_wait == 0);
            end
        end
    end

    initial begin
        int kind;
        int cycles;
        stim_rng        = SEED;
        lat_rng         = xorshift(SEED);
        txn_open        = 1'b0;
        txn_we          = 1'b0;
        fire            = 1'b0;
        slow_mem        = 1'b0;
        txn_wait        = 0;
        stall_cycles    = 0;
        store_idle_prev = 1'b1;
        rst_n_i         = 1'b0;
        load_valid_i    = 1'b0;
        load_signed_i   = 1'b0;
        load_opcode_i   = LDW;
        load_address_i  = BASE_ADDR;
        store_valid_i   = 1'b0;
        store_address_i = BASE_ADDR;
        store_data_i    = '0;
        mem_rdata_i     = '0;
        mem_ready_i     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i]   = fill_word(BASE_ADDR + 32'(4 * i));
            mem_model[i] = ref_mem[i];
        end
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Both units idle and the port quiet until something is issued
        repeat (4) begin
            @(negedge clk_i);
            check_value(32'(load_idle_o), 32'd1, "load_idle_o after reset");
            check_value(32'(store_idle_o), 32'd1, "store_idle_o after reset");
            check_value(32'(mem_req_o), 32'd0, "mem_req_o after reset");
        end
        for (int n = 0; n < N_OPS; n++) begin
            stim_rng = xorshift(stim_rng);
            kind     = (stim_rng[2:0] < 3'd3) ? 1 : ((stim_rng[2:0] < 3'd6) ? 2 : 0);
            issue_operation(kind);
        end
        // Back-to-back stores against a slow memory fill the buffer
        slow_mem <= 1'b1;
        for (int n = 0; n < N_BURST; n++) begin
            issue_operation(2);
        end
        issue_operation(0);
        cycles = 0;
        while (expect_q.size() != 0 || store_q.size() != 0 || txn_open) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                stop_with_failure("Pending loads or buffered stores never finished");
            end
        end
        check_value(32'(read_q.size()), 32'd0, "memory reads still expected");
        check_value(32'(stall_cycles > 0), 32'd1, "store back-pressure seen");
        foreach (mem_model[i]) begin
            check_value(mem_model[i], ref_mem[i], $sformatf("final memory word %0d", i));
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule : tb_load_store_unit

`default_nettype wire
